//--- common/mouse_defs.svh
`ifndef MOUSE_DEFS_SVH
`define MOUSE_DEFS_SVH

// PS/2 byte and receive error code widths
`define MOUSE_BYTE_W 8
`define MOUSE_ERR_W 2

// Number of entries in the init script table
`define MOUSE_SCRIPT_LEN 21

// 10 ms at 100 MHz
`define MOUSE_POWERUP_CYCLES 1000000

////////////////////////////////////////
// Sample rate arguments of the knock sequence
// Decimal 200, 100 and 80
`define MOUSE_RATE_A 8'hC8
`define MOUSE_RATE_B 8'h64
`define MOUSE_RATE_C 8'h50

////////////////////////////////////////
// Mouse responses
`define MOUSE_RESP_ACK 8'hFA
`define MOUSE_RESP_SELFTEST 8'hAA
// Device type after the get ID command
`define MOUSE_ID_PLAIN 8'h00
`define MOUSE_ID_SCROLL 8'h03

`endif

//--- common/mousePkg.sv
`default_nettype none

`include "mouse_defs.svh"

package mousePkg;

    ////////////////////////////////////////
    // Command opcodes sent by the host
    ////////////////////////////////////////
    typedef enum logic [`MOUSE_BYTE_W-1:0] {
        // Full reset of the mouse
        cmdReset   = 8'hFF,
        // Followed by one rate argument byte
        cmdSetRate = 8'hF3,
        // Read device type
        cmdGetId   = 8'hF2,
        // Start data reporting
        cmdEnable  = 8'hF4
    } mouseCmdE;

    ////////////////////////////////////////
    // Init script step kinds
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        // Transmit the step byte
        stepSend   = 2'd0,
        // Receive and compare with the step byte
        stepExpect = 2'd1,
        // Receive device ID and pick packet length
        stepIdent  = 2'd2
    } stepKindE;

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////
    // Init sequencer
    typedef enum logic [2:0] {
        initWait      = 3'd0,
        initIssue     = 3'd1,
        initSending   = 3'd2,
        initReceiving = 3'd3,
        initDone      = 3'd4
    } initStateE;

    // Packet reader
    typedef enum logic [2:0] {
        pktIdle   = 3'd0,
        pktStatus = 3'd1,
        pktDx     = 3'd2,
        pktDy     = 3'd3,
        pktDz     = 3'd4,
        pktIrq    = 3'd5
    } packetStateE;

endpackage

`default_nettype wire

//--- mouseInit/mouseInitSequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mouse_defs.svh"

module mouseInitSequencer #(
    parameter int unsigned powerUpCycles = `MOUSE_POWERUP_CYCLES
) (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        byteSent,
    input  wire                        byteReady,
    input  wire [`MOUSE_BYTE_W-1:0]    byteRead,
    input  wire [`MOUSE_ERR_W-1:0]     byteErrorCode,
    input  wire                        packetError,
    output logic                       sendByte,
    output logic [`MOUSE_BYTE_W-1:0]   byteToSend,
    output logic                       readEnable,
    output logic                       initDone,
    output logic                       scrollEnable
);

    // Counter runs 0 .. powerUpCycles-1
    localparam int cntW = (powerUpCycles > 1) ? $clog2(powerUpCycles) : 1;
    localparam int stepW = $clog2(`MOUSE_SCRIPT_LEN);
    localparam logic [cntW-1:0] lastCount = cntW'(powerUpCycles - 1);
    localparam logic [stepW-1:0] lastStep = stepW'(`MOUSE_SCRIPT_LEN - 1);

    ////////////////////////////////////////
    // Init script
    ////////////////////////////////////////
    localparam mousePkg::stepKindE scriptKind [`MOUSE_SCRIPT_LEN] = '{
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepExpect,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepSend,
        mousePkg::stepExpect,
        mousePkg::stepIdent,
        mousePkg::stepSend,
        mousePkg::stepExpect
    };

    // Byte to send, or byte to match on receive steps
    localparam logic [`MOUSE_BYTE_W-1:0] scriptByte [`MOUSE_SCRIPT_LEN] = '{
        // Reset, ack, self-test pass, initial ID
        mousePkg::cmdReset,
        `MOUSE_RESP_ACK,
        `MOUSE_RESP_SELFTEST,
        `MOUSE_ID_PLAIN,
        // Knock sequence for the scroll wheel
        mousePkg::cmdSetRate,
        `MOUSE_RESP_ACK,
        `MOUSE_RATE_A,
        `MOUSE_RESP_ACK,
        mousePkg::cmdSetRate,
        `MOUSE_RESP_ACK,
        `MOUSE_RATE_B,
        `MOUSE_RESP_ACK,
        mousePkg::cmdSetRate,
        `MOUSE_RESP_ACK,
        `MOUSE_RATE_C,
        `MOUSE_RESP_ACK,
        // Read device type again
        mousePkg::cmdGetId,
        `MOUSE_RESP_ACK,
        // Scroll ID here, plain ID also accepted
        `MOUSE_ID_SCROLL,
        // Start reporting
        mousePkg::cmdEnable,
        `MOUSE_RESP_ACK
    };

    mousePkg::initStateE state;
    logic [cntW-1:0] powerCount;
    logic [stepW-1:0] stepIdx;
    mousePkg::stepKindE stepKind;
    logic [`MOUSE_BYTE_W-1:0] stepByte;
    logic isLastStep;
    logic identOk;
    logic respOk;

    // Current table entry
    assign stepKind = scriptKind[stepIdx];
    assign stepByte = scriptByte[stepIdx];
    assign isLastStep = (stepIdx == lastStep);

    // Ident step takes either device type
    assign identOk = (byteRead == `MOUSE_ID_PLAIN) || (byteRead == stepByte);

    always_comb begin
        respOk = 1'b0;
        // Any receive error fails the step
        if (byteErrorCode == '0) begin
            if (stepKind == mousePkg::stepIdent)
                respOk = identOk;
            else
                respOk = (byteRead == stepByte);
        end
    end

    ////////////////////////////////////////
    // Script FSM
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= mousePkg::initWait;
            powerCount   <= '0;
            stepIdx      <= '0;
            sendByte     <= 1'b0;
            scrollEnable <= 1'b0;
        end else begin
            sendByte <= 1'b0;
            if (packetError) begin
                // Broken packet stream, start over
                state        <= mousePkg::initWait;
                powerCount   <= '0;
                stepIdx      <= '0;
                scrollEnable <= 1'b0;
            end else begin
                case (state)
                    mousePkg::initWait: begin
                        if (powerCount == lastCount) begin
                            powerCount <= '0;
                            stepIdx    <= '0;
                            state      <= mousePkg::initIssue;
                        end else begin
                            powerCount <= powerCount + 1'b1;
                        end
                    end
                    mousePkg::initIssue: begin
                        if (stepKind == mousePkg::stepSend) begin
                            sendByte <= 1'b1;
                            state    <= mousePkg::initSending;
                        end else begin
                            state <= mousePkg::initReceiving;
                        end
                    end
                    // Transceiver busy until byteSent
                    mousePkg::initSending: begin
                        if (byteSent) begin
                            if (isLastStep) begin
                                state <= mousePkg::initDone;
                            end else begin
                                stepIdx <= stepIdx + 1'b1;
                                state   <= mousePkg::initIssue;
                            end
                        end
                    end
                    mousePkg::initReceiving: begin
                        if (byteReady) begin
                            if (respOk) begin
                                if (stepKind == mousePkg::stepIdent)
                                    scrollEnable <= (byteRead == stepByte);
                                if (isLastStep) begin
                                    state <= mousePkg::initDone;
                                end else begin
                                    stepIdx <= stepIdx + 1'b1;
                                    state   <= mousePkg::initIssue;
                                end
                            end else begin
                                // Unexpected response
                                state        <= mousePkg::initWait;
                                powerCount   <= '0;
                                stepIdx      <= '0;
                                scrollEnable <= 1'b0;
                            end
                        end
                    end
                    // Packet reader owns the receiver now
                    mousePkg::initDone: begin
                        state <= mousePkg::initDone;
                    end
                    default: begin
                        state <= mousePkg::initWait;
                    end
                endcase
            end
        end
    end

    // Held from the send pulse until the next one
    always_ff @(posedge CLK) begin
        if (state == mousePkg::initIssue && stepKind == mousePkg::stepSend)
            byteToSend <= stepByte;
    end

    assign readEnable = (state == mousePkg::initReceiving);
    assign initDone = (state == mousePkg::initDone);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    sendPulseA: assert property (@(posedge CLK) disable iff (RESET)
        sendByte |=> !sendByte)
        else $error("sendByte high for more than one cycle");

    // Transmit and receive phases never overlap
    sendReadA: assert property (@(posedge CLK) disable iff (RESET)
        !(sendByte && readEnable))
        else $error("sendByte and readEnable high together");

endmodule

`default_nettype wire

//--- verilog/mousePacketReader.sv
`timescale 1ns/100ps
`default_nettype none

`include "mouse_defs.svh"

module mousePacketReader (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        initDone,
    input  wire                        scrollEnable,
    input  wire                        byteReady,
    input  wire [`MOUSE_BYTE_W-1:0]    byteRead,
    input  wire [`MOUSE_ERR_W-1:0]     byteErrorCode,
    output logic                       readEnable,
    output logic                       packetError,
    output logic [`MOUSE_BYTE_W-1:0]   mouseStatus,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDx,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDy,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDz,
    output logic                       sendInterrupt
);

    mousePkg::packetStateE state;
    logic byteBad;

    // Receiver open only while a packet byte is awaited
    assign readEnable = (state == mousePkg::pktStatus) || (state == mousePkg::pktDx) ||
                        (state == mousePkg::pktDy) || (state == mousePkg::pktDz);

    // Corrupted packet byte
    assign byteBad = readEnable && byteReady && (byteErrorCode != '0);

    ////////////////////////////////////////
    // Packet FSM
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= mousePkg::pktIdle;
            packetError   <= 1'b0;
            sendInterrupt <= 1'b0;
            mouseStatus   <= '0;
            mouseDx       <= '0;
            mouseDy       <= '0;
            mouseDz       <= '0;
        end else begin
            packetError   <= 1'b0;
            sendInterrupt <= 1'b0;
            if (!initDone) begin
                // Mouse not configured yet
                state <= mousePkg::pktIdle;
            end else if (byteBad) begin
                // Drop the packet, data keeps last values
                packetError <= 1'b1;
                state       <= mousePkg::pktIdle;
            end else begin
                case (state)
                    // Hold off while the sequencer sees the error
                    mousePkg::pktIdle: begin
                        if (!packetError)
                            state <= mousePkg::pktStatus;
                    end
                    mousePkg::pktStatus: begin
                        if (byteReady) begin
                            mouseStatus <= byteRead;
                            state       <= mousePkg::pktDx;
                        end
                    end
                    mousePkg::pktDx: begin
                        if (byteReady) begin
                            mouseDx <= byteRead;
                            state   <= mousePkg::pktDy;
                        end
                    end
                    // Plain mouse packet ends after dy
                    mousePkg::pktDy: begin
                        if (byteReady) begin
                            mouseDy <= byteRead;
                            if (scrollEnable)
                                state <= mousePkg::pktDz;
                            else
                                state <= mousePkg::pktIrq;
                        end
                    end
                    mousePkg::pktDz: begin
                        if (byteReady) begin
                            mouseDz <= byteRead;
                            state   <= mousePkg::pktIrq;
                        end
                    end
                    mousePkg::pktIrq: begin
                        sendInterrupt <= 1'b1;
                        state         <= mousePkg::pktStatus;
                    end
                    default: begin
                        state <= mousePkg::pktIdle;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    irqPulseA: assert property (@(posedge CLK) disable iff (RESET)
        sendInterrupt |=> !sendInterrupt)
        else $error("sendInterrupt high for more than one cycle");

    // A failed packet never raises an interrupt
    errIrqA: assert property (@(posedge CLK) disable iff (RESET)
        !(packetError && sendInterrupt))
        else $error("packetError and sendInterrupt together");

endmodule

`default_nettype wire

//--- verilog/mouseMaster.sv
`timescale 1ns/100ps
`default_nettype none

`include "mouse_defs.svh"

module mouseMaster #(
    parameter int unsigned powerUpCycles = `MOUSE_POWERUP_CYCLES
) (
    input  wire                        CLK,
    input  wire                        RESET,
    // Transceiver side
    output logic                       sendByte,
    output logic [`MOUSE_BYTE_W-1:0]   byteToSend,
    input  wire                        byteSent,
    output logic                       readEnable,
    input  wire                        byteReady,
    input  wire [`MOUSE_BYTE_W-1:0]    byteRead,
    input  wire [`MOUSE_ERR_W-1:0]     byteErrorCode,
    // System side
    output logic [`MOUSE_BYTE_W-1:0]   mouseStatus,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDx,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDy,
    output logic [`MOUSE_BYTE_W-1:0]   mouseDz,
    output logic                       sendInterrupt
);

    logic initDone;
    logic scrollEnable;
    logic packetError;
    logic seqReadEnable;
    logic pktReadEnable;

    ////////////////////////////////////////
    // Init script and power-up delay
    ////////////////////////////////////////
    mouseInitSequencer #(
        .powerUpCycles (powerUpCycles)
    ) u_sequencer (
        .CLK           (CLK),
        .RESET         (RESET),
        .byteSent      (byteSent),
        .byteReady     (byteReady),
        .byteRead      (byteRead),
        .byteErrorCode (byteErrorCode),
        .packetError   (packetError),
        .sendByte      (sendByte),
        .byteToSend    (byteToSend),
        .readEnable    (seqReadEnable),
        .initDone      (initDone),
        .scrollEnable  (scrollEnable)
    );

    ////////////////////////////////////////
    // Movement packets
    ////////////////////////////////////////
    mousePacketReader u_reader (
        .CLK           (CLK),
        .RESET         (RESET),
        .initDone      (initDone),
        .scrollEnable  (scrollEnable),
        .byteReady     (byteReady),
        .byteRead      (byteRead),
        .byteErrorCode (byteErrorCode),
        .readEnable    (pktReadEnable),
        .packetError   (packetError),
        .mouseStatus   (mouseStatus),
        .mouseDx       (mouseDx),
        .mouseDy       (mouseDy),
        .mouseDz       (mouseDz),
        .sendInterrupt (sendInterrupt)
    );

    // Reader only listens after init, so at most one request is active
    assign readEnable = seqReadEnable | pktReadEnable;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    readOwnerA: assert property (@(posedge CLK) disable iff (RESET)
        !(seqReadEnable && pktReadEnable))
        else $error("sequencer and reader both request the receiver");

    // Packet error restarts the script on the next edge
    restartA: assert property (@(posedge CLK) disable iff (RESET)
        packetError |=> !initDone)
        else $error("initDone still high after packetError");

endmodule

`default_nettype wire

//--- test/mouseMasterTb.sv
`timescale 1ns/100ps
`default_nettype none

module mouseMasterTb;

    localparam int clkPeriod = 40;
    localparam int powerUp = 50;
    localparam int rowCount = 46;
    // Four inits in the table, two of them cut short
    localparam int initCount = 4;
    localparam int timeoutCycles = rowCount * 40 + powerUp * initCount + 1000;

    ////////////////////////////////////////
    // Response table
    ////////////////////////////////////////
    // Bit 10 kind (1 = packet byte, 0 = init response)
    // Bits 9:8 receive error code, bits 7:0 data byte
    localparam logic [10:0] respTable [rowCount] = '{
        // Full init, wheel mouse
        11'h0FA, 11'h0AA, 11'h000,
        11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA,
        11'h0FA, 11'h003, 11'h0FA,
        // Two four-byte packets
        11'h408, 11'h405, 11'h4FB, 11'h401,
        11'h428, 11'h410, 11'h4F0, 11'h4FF,
        // Dx byte corrupted
        11'h409, 11'h512,
        // NAK in place of the ack after set rate
        11'h0FA, 11'h0AA, 11'h000, 11'h0FE,
        // Self-test byte with a receive error
        11'h0FA, 11'h2AA,
        // Full init, plain mouse
        11'h0FA, 11'h0AA, 11'h000,
        11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA, 11'h0FA,
        11'h0FA, 11'h000, 11'h0FA,
        // Two three-byte packets
        11'h418, 11'h47F, 11'h480,
        11'h400, 11'h401, 11'h402
    };

    // Host commands: reset, 200/100/80 knock, get ID, enable
    localparam logic [7:0] expSend [9] = '{
        8'hFF, 8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF2, 8'hF4
    };

    logic CLK;
    logic RESET;
    logic sendByte;
    logic [7:0] byteToSend;
    logic byteSent;
    logic readEnable;
    logic byteReady;
    logic [7:0] byteRead;
    logic [1:0] byteErrorCode;
    logic [7:0] mouseStatus;
    logic [7:0] mouseDx;
    logic [7:0] mouseDy;
    logic [7:0] mouseDz;
    logic sendInterrupt;

    // Shared between stimulus and the mouse transmit model
    int sendIdx = 0;
    int restartCycle = 0;
    int cycleCount = 0;
    int irqCount = 0;

    mouseMaster #(
        .powerUpCycles (powerUp)
    ) u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .sendByte      (sendByte),
        .byteToSend    (byteToSend),
        .byteSent      (byteSent),
        .readEnable    (readEnable),
        .byteReady     (byteReady),
        .byteRead      (byteRead),
        .byteErrorCode (byteErrorCode),
        .mouseStatus   (mouseStatus),
        .mouseDx       (mouseDx),
        .mouseDy       (mouseDy),
        .mouseDz       (mouseDz),
        .sendInterrupt (sendInterrupt)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    always @(posedge CLK) cycleCount <= cycleCount + 1;

    // Counted away from the rising edge
    always @(negedge CLK) begin
        if (sendInterrupt)
            irqCount <= irqCount + 1;
    end

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "check mismatch");
        end
    endtask

    // Step to just after the next rising edge
    task automatic waitCycle();
        @(posedge CLK);
        #1;
    endtask

    // Next host byte must be a fresh FF after a new power-up wait
    task automatic markRestart();
        sendIdx = 0;
        restartCycle = cycleCount;
    endtask

    // Init response expected at a script position, ident slot excluded
    function automatic logic [7:0] initResponse(input int idx);
        if (idx == 1)
            return 8'hAA;
        else if (idx == 2)
            return 8'h00;
        else
            return 8'hFA;
    endfunction

    ////////////////////////////////////////
    // Mouse transmit side
    ////////////////////////////////////////
    initial begin : mouseTx
        int unsigned seedVal;
        int delay;
        seedVal = $urandom(32'h08fcea28);
        forever begin
            waitCycle();
            if (sendByte) begin
                // First command only after the full power-up wait
                if (sendIdx == 0)
                    checkEqual(cycleCount - restartCycle >= powerUp, 1, "power-up wait");
                checkEqual(sendIdx < 9, 1, "more commands than the script holds");
                checkEqual(byteToSend, expSend[sendIdx], "byteToSend");
                sendIdx++;
                delay = $urandom_range(9, 2);
                repeat (delay) waitCycle();
                byteSent = 1'b1;
                waitCycle();
                byteSent = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("Timeout: run did not finish within %0d clock cycles", timeoutCycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Reset, responses and packet checks
    ////////////////////////////////////////
    initial begin : stimulus
        logic [10:0] entry;
        logic good;
        logic scrollMode;
        logic [7:0] expReg [4];
        int initIdx;
        int pktPos;
        int expIrq;
        RESET = 1'b1;
        byteSent = 1'b0;
        byteReady = 1'b0;
        byteRead = '0;
        byteErrorCode = '0;
        initIdx = 0;
        pktPos = 0;
        expIrq = 0;
        scrollMode = 1'b0;
        for (int i = 0; i < 4; i++)
            expReg[i] = '0;
        repeat (5) waitCycle();
        // Outputs idle and registers clear in reset
        checkEqual(sendByte, 0, "sendByte in reset");
        checkEqual(readEnable, 0, "readEnable in reset");
        checkEqual(sendInterrupt, 0, "sendInterrupt in reset");
        checkEqual({mouseStatus, mouseDx, mouseDy, mouseDz}, 0, "data registers in reset");
        RESET = 1'b0;
        restartCycle = cycleCount;
        for (int row = 0; row < rowCount; row++) begin
            entry = respTable[row];
            // One byte per cycle that the host listens
            waitCycle();
            while (!readEnable)
                waitCycle();
            byteReady = 1'b1;
            byteRead = entry[7:0];
            byteErrorCode = entry[9:8];
            waitCycle();
            byteReady = 1'b0;
            byteErrorCode = '0;
            if (!entry[10]) begin
                // Slot 10 is the device type after get ID
                if (initIdx == 10)
                    good = (entry[7:0] == 8'h00) || (entry[7:0] == 8'h03);
                else
                    good = (entry[7:0] == initResponse(initIdx));
                if (entry[9:8] != 2'd0 || !good) begin
                    initIdx = 0;
                    markRestart();
                end else begin
                    if (initIdx == 10)
                        scrollMode = (entry[7:0] == 8'h03);
                    initIdx++;
                    if (initIdx == 12) begin
                        checkEqual(sendIdx, 9, "command count at end of init");
                        initIdx = 0;
                        pktPos = 0;
                    end
                end
            end else if (entry[9:8] != 2'd0) begin
                // Packet dropped, earlier bytes stay stored
                pktPos = 0;
                markRestart();
            end else begin
                expReg[pktPos] = entry[7:0];
                pktPos++;
                if (pktPos == (scrollMode ? 4 : 3)) begin
                    pktPos = 0;
                    expIrq++;
                    // Interrupt follows one edge after the last byte is stored
                    waitCycle();
                    checkEqual(sendInterrupt, 1, "sendInterrupt after last packet byte");
                    checkEqual(mouseStatus, expReg[0], "mouseStatus");
                    checkEqual(mouseDx, expReg[1], "mouseDx");
                    checkEqual(mouseDy, expReg[2], "mouseDy");
                    // Plain packets leave dz alone
                    checkEqual(mouseDz, expReg[3], "mouseDz");
                end
            end
        end
        repeat (3) waitCycle();
        checkEqual(irqCount, expIrq, "interrupt count");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/mousePkg.sv
mouseInit/mouseInitSequencer.sv
verilog/mousePacketReader.sv
verilog/mouseMaster.sv
test/mouseMasterTb.sv

//--- Bender.yml
package:
  name: mouse_master

sources:
  - include_dirs:
      - common
    files:
      - common/mousePkg.sv
      - mouseInit/mouseInitSequencer.sv
      - verilog/mousePacketReader.sv
      - verilog/mouseMaster.sv
  - target: test
    files:
      - test/mouseMasterTb.sv
